// File: logic/i2si_pkg.sv
package i2si_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// One audio word per channel
	localparam int SAMPLE_W = 16;

	// Wishbone data bus and word address
	localparam int WB_DW = 32;
	localparam int WB_AW = 4;

	//////////////////////////////////////////////////
	// Register map, word addresses
	//////////////////////////////////////////////////

	localparam logic [WB_AW-1:0] ADR_CTRL       = 4'd0;
	localparam logic [WB_AW-1:0] ADR_STATUS     = 4'd1;
	// Port p frame sits at base plus p
	localparam logic [WB_AW-1:0] ADR_FRAME_BASE = 4'd2;

	// One sampling event per port per clock
	typedef struct packed {
		logic sck_rise;
		logic ws;
		logic sd;
	} i2si_bit_t;

	// Stereo frame, also the frame register layout
	typedef struct packed {
		logic [SAMPLE_W-1:0] rgt;
		logic [SAMPLE_W-1:0] lft;
	} i2si_frame_t;

	// Wishbone request from the master
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

endpackage

// File: logic/i2si_sync.sv
`timescale 1ns/1ps

module i2si_sync #(
	parameter int NUM_PORTS = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [NUM_PORTS-1:0] i2si_sck,
	input  logic [NUM_PORTS-1:0] i2si_ws,
	input  logic [NUM_PORTS-1:0] i2si_sd,
	output i2si_pkg::i2si_bit_t  bit_evt [NUM_PORTS]
);

	// First synchronizer stage
	logic [NUM_PORTS-1:0] sck_s1;
	logic [NUM_PORTS-1:0] ws_s1;
	logic [NUM_PORTS-1:0] sd_s1;

	// Second stage, safe to use
	logic [NUM_PORTS-1:0] sck_s2;
	logic [NUM_PORTS-1:0] ws_s2;
	logic [NUM_PORTS-1:0] sd_s2;

	// Previous sck for edge detection
	logic [NUM_PORTS-1:0] sck_prev;

	//////////////////////////////////////////////////
	// Two-flop synchronizers, all ports at once
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sck_s1   <= '0;
			ws_s1    <= '0;
			sd_s1    <= '0;
			sck_s2   <= '0;
			ws_s2    <= '0;
			sd_s2    <= '0;
			sck_prev <= '0;
		end
		else
		begin
			sck_s1   <= i2si_sck;
			ws_s1    <= i2si_ws;
			sd_s1    <= i2si_sd;
			sck_s2   <= sck_s1;
			ws_s2    <= ws_s1;
			sd_s2    <= sd_s1;
			// Held copy of sck, compared below
			sck_prev <= sck_s2;
		end
	end

	//////////////////////////////////////////////////
	// Edge register, ws and sd ride along
	//////////////////////////////////////////////////

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_evt
		always_ff @(posedge clk)
		begin
			if (rst)
				bit_evt[p] <= '0;
			else
			begin
				// Rising sck, low to high
				bit_evt[p].sck_rise <= sck_s2[p] & ~sck_prev[p];
				bit_evt[p].ws       <= ws_s2[p];
				bit_evt[p].sd       <= sd_s2[p];
			end
		end

		// sck is far slower than clk, so a rise lasts one cycle
		a_rise_single : assert property (@(posedge clk) disable iff (rst)
			bit_evt[p].sck_rise |=> !bit_evt[p].sck_rise);
	end

endmodule

// File: logic/i2si_deserializer.sv
`timescale 1ns/1ps

module i2si_deserializer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  en,
	input  i2si_pkg::i2si_bit_t   bit_evt,
	output i2si_pkg::i2si_frame_t frame,
	output logic                  xfc
);

	import i2si_pkg::*;

	// Counter runs 0..SAMPLE_W, SAMPLE_W means idle
	localparam int CNT_W = $clog2(SAMPLE_W + 1);

	// ws seen at the previous sck rise
	logic ws_prev;

	// Bits taken so far in the current word
	logic [CNT_W-1:0] cnt;

	// Left word held, waiting for its right partner
	logic lft_vld;

	// Shift register and held left word
	logic [SAMPLE_W-1:0] shreg;
	logic [SAMPLE_W-1:0] lft_hold;

	// Word including the bit sampled now
	logic [SAMPLE_W-1:0] word;

	// Per-event decode
	logic boundary;
	logic take_bit;
	logic word_done;
	logic frm_load;

	//////////////////////////////////////////////////
	// Event decode
	//////////////////////////////////////////////////

	// ws change marks the start of a new word
	assign boundary  = bit_evt.sck_rise && (bit_evt.ws != ws_prev);

	// Bits after the 16th are padding
	assign take_bit  = bit_evt.sck_rise && !boundary && (cnt != CNT_W'(SAMPLE_W));
	assign word_done = take_bit && (cnt == CNT_W'(SAMPLE_W - 1));

	// MSB first, so shift in at the bottom
	assign word      = {shreg[SAMPLE_W-2:0], bit_evt.sd};

	// Right word completing with a left word in hand
	assign frm_load  = en && word_done && bit_evt.ws && lft_vld;

	//////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////

	// Track ws even while disabled, so enabling mid-word
	// does not look like a boundary
	always_ff @(posedge clk)
	begin
		if (rst)
			ws_prev <= 1'b0;
		else if (bit_evt.sck_rise)
			ws_prev <= bit_evt.ws;
	end

	always_ff @(posedge clk)
	begin
		if (rst || !en)
		begin
			// Idle until the next ws change
			cnt     <= CNT_W'(SAMPLE_W);
			lft_vld <= 1'b0;
			xfc     <= 1'b0;
		end
		else
		begin
			xfc <= frm_load;
			// Boundary bit is the previous word's LSB, dropped
			if (boundary)
				cnt <= '0;
			else if (take_bit)
				cnt <= cnt + 1'b1;
			if (word_done && !bit_evt.ws)
				lft_vld <= 1'b1;
			else if (frm_load)
				lft_vld <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Payload
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (take_bit)
			shreg <= word;
		// Left channel while ws is low
		if (word_done && !bit_evt.ws)
			lft_hold <= word;
		if (frm_load)
		begin
			frame.rgt <= word;
			frame.lft <= lft_hold;
		end
	end

	// One frame per two slots, never back to back
	a_xfc_single : assert property (@(posedge clk) disable iff (rst)
		xfc |=> !xfc);

endmodule

// File: logic/i2si_wb_regs.sv
`timescale 1ns/1ps

module i2si_wb_regs #(
	parameter int NUM_PORTS = 2
) (
	input  logic                        clk,
	input  logic                        rst,
	input  i2si_pkg::wb_req_t           wb_req,
	output logic [i2si_pkg::WB_DW-1:0]  wb_dat_r,
	output logic                        wb_ack,
	input  i2si_pkg::i2si_frame_t       frame_in [NUM_PORTS],
	input  logic [NUM_PORTS-1:0]        xfc,
	output logic [NUM_PORTS-1:0]        en,
	output logic                        irq
);

	import i2si_pkg::*;

	// Overrun flags start at this STATUS bit
	localparam int OVR_LSB = 8;

	// Sticky flags per port
	logic [NUM_PORTS-1:0] rdy;
	logic [NUM_PORTS-1:0] ovr;

	// Stored frames, one per port
	i2si_frame_t frm_q [NUM_PORTS];

	// Access accepted this cycle, ack follows
	logic acc;
	logic wr_ctrl;
	logic wr_status;
	logic rd_frame;

	// Frame register hit, one-hot over ports
	logic [NUM_PORTS-1:0] frm_sel;

	// Flag clears from the bus
	logic [NUM_PORTS-1:0] rdy_clr;
	logic [NUM_PORTS-1:0] ovr_clr;

	// Read mux output
	logic [WB_DW-1:0] rd_data;

	//////////////////////////////////////////////////
	// Access decode
	//////////////////////////////////////////////////

	// New request only when no ack is pending
	assign acc       = wb_req.cyc && wb_req.stb && !wb_ack;
	assign wr_ctrl   = acc && wb_req.we && (wb_req.adr == ADR_CTRL);
	assign wr_status = acc && wb_req.we && (wb_req.adr == ADR_STATUS);
	assign rd_frame  = acc && !wb_req.we;

	// Write-one-to-clear, plus frame reads clear ready
	assign rdy_clr = (wr_status ? wb_req.dat[NUM_PORTS-1:0] : '0)
		| (rd_frame ? frm_sel : '0);
	assign ovr_clr = wr_status ? wb_req.dat[OVR_LSB +: NUM_PORTS] : '0;

	always_comb
	begin
		rd_data = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			frm_sel[p] = (wb_req.adr == ADR_FRAME_BASE + WB_AW'(p));
			if (frm_sel[p])
				rd_data = frm_q[p];
		end
		// Unmapped addresses fall through as zero
		if (wb_req.adr == ADR_CTRL)
			rd_data[NUM_PORTS-1:0] = en;
		else if (wb_req.adr == ADR_STATUS)
		begin
			rd_data[NUM_PORTS-1:0]         = rdy;
			rd_data[OVR_LSB +: NUM_PORTS] = ovr;
		end
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_ack <= 1'b0;
			en     <= '0;
			rdy    <= '0;
			ovr    <= '0;
			irq    <= 1'b0;
			for (int p = 0; p < NUM_PORTS; p++)
				frm_q[p] <= '0;
		end
		else
		begin
			wb_ack <= acc;
			if (wr_ctrl)
				en <= wb_req.dat[NUM_PORTS-1:0];
			// Set from xfc wins over a clear
			rdy <= (rdy & ~rdy_clr) | xfc;
			// Overrun when the old frame was never read
			ovr <= (ovr & ~ovr_clr) | (xfc & rdy);
			// Interrupt from enabled ports only
			irq <= |(rdy & en);
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				if (xfc[p])
					frm_q[p] <= frame_in[p];
			end
		end
	end

	// Read data, valid with ack
	always_ff @(posedge clk)
	begin
		if (rd_frame)
			wb_dat_r <= rd_data;
	end

	// Master holds the request through the ack cycle
	a_ack_in_cycle : assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> (wb_req.cyc && wb_req.stb));

endmodule

// File: logic/i2si_top.sv
`timescale 1ns/1ps

module i2si_top #(
	parameter int NUM_PORTS = 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [NUM_PORTS-1:0]       i2si_sck,
	input  logic [NUM_PORTS-1:0]       i2si_ws,
	input  logic [NUM_PORTS-1:0]       i2si_sd,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [i2si_pkg::WB_AW-1:0] wb_adr,
	input  logic [i2si_pkg::WB_DW-1:0] wb_dat_w,
	output logic [i2si_pkg::WB_DW-1:0] wb_dat_r,
	output logic                       wb_ack,
	output logic                       irq
);

	import i2si_pkg::*;

	// Bus pins bundled for the register block
	wb_req_t wb_req;

	// Synchronized events, one per port
	i2si_bit_t bit_evt [NUM_PORTS];

	// Deserializer outputs and enables
	i2si_frame_t frame [NUM_PORTS];
	logic [NUM_PORTS-1:0] xfc;
	logic [NUM_PORTS-1:0] en;

	assign wb_req = '{cyc: wb_cyc, stb: wb_stb, we: wb_we, adr: wb_adr, dat: wb_dat_w};

	//////////////////////////////////////////////////
	// I2S pins into the clk domain
	//////////////////////////////////////////////////

	i2si_sync #(.NUM_PORTS(NUM_PORTS)) i_sync (
		.clk      (clk),
		.rst      (rst),
		.i2si_sck (i2si_sck),
		.i2si_ws  (i2si_ws),
		.i2si_sd  (i2si_sd),
		.bit_evt  (bit_evt)
	);

	// One deserializer per port
	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		i2si_deserializer i_deser (
			.clk     (clk),
			.rst     (rst),
			.en      (en[p]),
			.bit_evt (bit_evt[p]),
			.frame   (frame[p]),
			.xfc     (xfc[p])
		);
	end

	// Control, status, frame registers and irq
	i2si_wb_regs #(.NUM_PORTS(NUM_PORTS)) i_regs (
		.clk      (clk),
		.rst      (rst),
		.wb_req   (wb_req),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.frame_in (frame),
		.xfc      (xfc),
		.en       (en),
		.irq      (irq)
	);

endmodule

// File: tests/i2si_tb.sv
`timescale 1ns/1ps

module i2si_tb;

	import i2si_pkg::*;

	localparam int NUM_PORTS  = 2;
	// One left plus one right slot, 40 sck periods of 16 clocks
	localparam int FRAME_CLKS = 640;
	// Three times ten frames
	localparam int MAX_CYCLES = 3 * 10 * FRAME_CLKS;

	logic                 clk = 1'b0;
	logic                 rst;
	logic [NUM_PORTS-1:0] i2si_sck;
	logic [NUM_PORTS-1:0] i2si_ws;
	logic [NUM_PORTS-1:0] i2si_sd;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [WB_AW-1:0]     wb_adr;
	logic [WB_DW-1:0]     wb_dat_w;
	logic [WB_DW-1:0]     wb_dat_r;
	logic                 wb_ack;
	logic                 irq;

	int seed = 95;
	int cycles = 0;
	// Enable bits as the model sees them
	logic [NUM_PORTS-1:0] model_en = '0;
	// Transmitter position, channel and bit in slot
	int tx_ch [NUM_PORTS];
	int tx_bit [NUM_PORTS];
	int checked [NUM_PORTS];
	// Frames sent while enabled, rgt upper half
	logic [31:0] exp_q0 [$];
	logic [31:0] exp_q1 [$];

	i2si_top #(.NUM_PORTS(NUM_PORTS)) i_dut (
		.clk(clk), .rst(rst), .i2si_sck(i2si_sck), .i2si_ws(i2si_ws), .i2si_sd(i2si_sd),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .irq(irq)
	);

	initial
	begin
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Failure reporting and checks
	//////////////////////////////////////////////////

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic fail_with(input string why);
		$display("ERROR at %0t: %s", $time, why);
		abort_run();
	endtask

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Run length guard
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			fail_with($sformatf("timeout, run passed %0d cycles", MAX_CYCLES));
	end

	//////////////////////////////////////////////////
	// I2S transmitter, standard format
	//////////////////////////////////////////////////

	task automatic drive_port(input int p);
		logic [SAMPLE_W-1:0] word;
		logic [SAMPLE_W-1:0] lft_w;
		bit armed;
		armed = 1'b0;
		// Ports offset by 3 clocks
		repeat (3 * p) @(negedge clk);
		forever
		begin
			for (int ch = 0; ch < 2; ch++)
			begin
				word = SAMPLE_W'($random(seed));
				if (ch == 0)
					lft_w = word;
				for (int b = 0; b < 20; b++)
				begin
					// Falling sck, ws and sd move
					tx_ch[p]    = ch;
					tx_bit[p]   = b;
					i2si_sck[p] = 1'b0;
					i2si_ws[p]  = (ch == 1);
					// Bit 0 is the delay bit, 17..19 padding
					if (b >= 1 && b <= 16)
						i2si_sd[p] = word[16 - b];
					else
						i2si_sd[p] = 1'($random(seed));
					repeat (8) @(negedge clk);
					i2si_sck[p] = 1'b1;
					// Left word must start while enabled
					if (ch == 0 && b == 0)
						armed = model_en[p];
					if (ch == 1 && b == 16 && armed && model_en[p])
					begin
						if (p == 0)
							exp_q0.push_back({word, lft_w});
						else
							exp_q1.push_back({word, lft_w});
					end
					repeat (8) @(negedge clk);
				end
			end
		end
	endtask

	task automatic wait_slot(input int p, input int ch, input int b);
		wait (tx_ch[p] == ch && tx_bit[p] == b);
	endtask

	//////////////////////////////////////////////////
	// Wishbone master and polling
	//////////////////////////////////////////////////

	task automatic wb_cycle(input logic we, input logic [WB_AW-1:0] adr,
		input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat, output logic irq_s);
		int waited;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		waited   = 0;
		@(negedge clk);
		while (!wb_ack)
		begin
			waited++;
			if (waited >= 4)
				fail_with($sformatf("no Wishbone ack within 4 cycles, address %0d", adr));
			@(negedge clk);
		end
		rdat  = wb_dat_r;
		irq_s = irq;
		// Request held through the ack edge
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	// One STATUS read, drain every ready port
	task automatic service();
		logic [WB_DW-1:0] st;
		logic [WB_DW-1:0] st2;
		logic [WB_DW-1:0] frm;
		logic [31:0] exp;
		logic irq_s;
		wb_cycle(1'b0, ADR_STATUS, '0, st, irq_s);
		check_equal("irq", 32'(irq_s), 32'(|(st[1:0] & model_en)));
		check_equal("STATUS overrun", 32'(st[9:8]), '0);
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (st[p])
			begin
				if (!model_en[p])
					fail_with($sformatf("port %0d ready while disabled", p));
				if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0))
					fail_with($sformatf("port %0d ready with no frame sent", p));
				if (p == 0)
					exp = exp_q0.pop_front();
				else
					exp = exp_q1.pop_front();
				wb_cycle(1'b0, ADR_FRAME_BASE + WB_AW'(p), '0, frm, irq_s);
				check_equal($sformatf("frame %0d", p), frm, exp);
				checked[p]++;
			end
		end
		if (st[1:0] != 2'b00)
		begin
			// Frame reads clear ready, irq follows
			wb_cycle(1'b0, ADR_STATUS, '0, st2, irq_s);
			check_equal("STATUS ready after read", 32'(st2[1:0] & st[1:0]), '0);
			check_equal("irq after read", 32'(irq_s), 32'(|(st2[1:0] & model_en)));
		end
	endtask

	task automatic poll_for(input int n);
		int t_end;
		t_end = cycles + n;
		while (cycles < t_end)
			service();
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic [WB_DW-1:0] rd;
		logic [31:0] last0;
		logic irq_s;
		int base;
		rst      = 1'b1;
		i2si_sck = '0;
		i2si_ws  = '0;
		i2si_sd  = '0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		fork
			drive_port(0);
			drive_port(1);
		join_none
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Quiet bus after reset, all registers zero
		@(negedge clk);
		check_equal("irq after reset", 32'(irq), '0);
		check_equal("wb_ack after reset", 32'(wb_ack), '0);
		for (int a = 0; a < 4; a++)
		begin
			wb_cycle(1'b0, WB_AW'(a), '0, rd, irq_s);
			check_equal($sformatf("register %0d after reset", a), rd, '0);
		end

		// Enable mid right word, ten frames per port
		wait_slot(0, 1, 8);
		wb_cycle(1'b1, ADR_CTRL, 32'd3, rd, irq_s);
		model_en = 2'b11;
		while (checked[0] < 10 || checked[1] < 10)
			service();

		// Port 1 off for two frames
		wait_slot(1, 0, 8);
		service();
		wb_cycle(1'b1, ADR_CTRL, 32'd1, rd, irq_s);
		model_en = 2'b01;
		poll_for(2 * FRAME_CLKS);
		check_equal("port 1 frames while disabled", exp_q1.size(), '0);
		// Back on partway through a right word
		wait_slot(1, 1, 8);
		wb_cycle(1'b1, ADR_CTRL, 32'd3, rd, irq_s);
		model_en = 2'b11;
		base = checked[1];
		while (checked[1] == base)
			service();

		// No polling for two frame times
		wait_slot(0, 0, 8);
		service();
		repeat (2 * FRAME_CLKS) @(negedge clk);
		wb_cycle(1'b0, ADR_STATUS, '0, rd, irq_s);
		check_equal("STATUS ready", 32'(rd[1:0]), 32'd3);
		check_equal("STATUS overrun", 32'(rd[9:8]), 32'd3);
		check_equal("irq with ready", 32'(irq_s), 32'd1);
		last0 = exp_q0[$];
		wb_cycle(1'b0, ADR_FRAME_BASE, '0, rd, irq_s);
		check_equal("frame 0 after overrun", rd, last0);
		wb_cycle(1'b0, ADR_FRAME_BASE + WB_AW'(1), '0, rd, irq_s);
		check_equal("frame 1 after overrun", rd, exp_q1[$]);
		exp_q0.delete();
		exp_q1.delete();
		wb_cycle(1'b1, ADR_STATUS, 32'h300, rd, irq_s);
		wb_cycle(1'b0, ADR_STATUS, '0, rd, irq_s);
		check_equal("STATUS after clear", rd, '0);
		check_equal("irq after clear", 32'(irq_s), '0);

		// Frame register is read only, unmapped reads zero
		wb_cycle(1'b1, ADR_FRAME_BASE, $random(seed), rd, irq_s);
		wb_cycle(1'b0, ADR_FRAME_BASE, '0, rd, irq_s);
		check_equal("frame 0 after write", rd, last0);
		wb_cycle(1'b0, 4'd4, '0, rd, irq_s);
		check_equal("unmapped address 4", rd, '0);
		wb_cycle(1'b0, 4'd15, '0, rd, irq_s);
		check_equal("unmapped address 15", rd, '0);

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: compile.f
logic/i2si_pkg.sv
logic/i2si_sync.sv
logic/i2si_deserializer.sv
logic/i2si_wb_regs.sv
logic/i2si_top.sv
tests/i2si_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I2S receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module i2si_tb \
	-Mdir obj_dir -o sim_i2si -f compile.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_i2si > "$LOG" 2>&1
status=$?
cat "$LOG"

# The log decides the verdict
if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0
